// ==== all.f ====
spectrum_bus_pkg.sv
spectrum_mem_pkg.sv
page_registers.sv
address_mapper.sv
joystick_mapper.sv
io_ports.sv
zx_mem_top.sv
zx_mem_checker.sv
tb_zx_mem.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP       = tb_zx_mem
FILELIST  = all.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = === FAIL ===
PASS_MSG  = === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation did not complete"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_zx_mem.sv ====
/*
 * Testbench for the Spectrum paging and I/O core
 * Clock and reset, bus drive helpers, compare tasks,
 * directed tests and the closing report
 */

`timescale 1ns/100ps

module tb_zx_mem
	import spectrum_bus_pkg::*, spectrum_mem_pkg::*;
();

	localparam int CLK_HALF      = 10;
	localparam int DRIVE_DLY     = 2;
	localparam int RESET_CYCLES  = 3;
	localparam int RESET_TIMEOUT = 20;

	typedef struct packed {
		logic [2:0] border;
		logic       ear;
		logic       mic;
	} ula_t;

	logic       clk_sys;
	logic       reset;
	machine_e   machine;
	cpu_bus_t   bus;
	logic [7:0] ram_dout;
	logic [4:0] key_data;
	logic       tape_in;
	joy_t       joy0;
	joy_t       joy1;
	joy_mode_e  joy_mode;
	mem_req_t   mem;
	logic [7:0] cpu_din;
	logic [2:0] border;
	logic       ear;
	logic       mic;

	int         errors;
	int         checks;
	logic [7:0] lfsr;
	event       reset_req;

	zx_mem_top UUT (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.machine  (machine),
		.bus      (bus),
		.ram_dout (ram_dout),
		.key_data (key_data),
		.tape_in  (tape_in),
		.joy0     (joy0),
		.joy1     (joy1),
		.joy_mode (joy_mode),
		.mem      (mem),
		.cpu_din  (cpu_din),
		.border   (border),
		.ear      (ear),
		.mic      (mic)
	);

	initial clk_sys = 1'b0;
	always #CLK_HALF clk_sys = ~clk_sys;

	// Reset pulse of RESET_CYCLES clocks at power-on and on request
	initial begin
		reset = 1'b1;
		forever begin
			for (int i = 0; i < RESET_CYCLES; i++) begin
				@(posedge clk_sys);
			end
			#DRIVE_DLY reset = 1'b0;
			@(reset_req);
			reset = 1'b1;
		end
	end

	// ==================================================
	// Helpers
	// ==================================================

	// Galois LFSR with taps x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic lfsr_bit();
		logic b;
		b = lfsr[0];
		lfsr = {1'b0, lfsr[7:1]} ^ (b ? 8'hB8 : 8'h00);
		return b;
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [7:0] v;
		v = 8'h00;
		for (int i = 0; i < 8; i++) begin
			v = {v[6:0], lfsr_bit()};
		end
		return v;
	endfunction

	function automatic mem_addr_t rom_addr(input logic [3:0] page, input logic [15:0] a);
		return {4'b0000, ROM_BASE_TAG, page, a[13:0]};
	endfunction

	function automatic mem_addr_t ram_addr(input logic [2:0] bank, input logic [15:0] a);
		return {4'b0000, RAM_BASE_TAG, bank, a[13:0]};
	endfunction

	// +3 all-RAM bank tables with slot 0 in the top bits
	function automatic logic [2:0] special_bank(input int cfg, input int slot);
		logic [11:0] row;
		case (cfg)
			0: row = {3'd0, 3'd1, 3'd2, 3'd3};
			1: row = {3'd4, 3'd5, 3'd6, 3'd7};
			2: row = {3'd4, 3'd5, 3'd6, 3'd3};
			default: row = {3'd4, 3'd7, 3'd6, 3'd3};
		endcase
		return row[(3 - slot) * 3 +: 3];
	endfunction

	task automatic next_cycle();
		@(posedge clk_sys);
		#DRIVE_DLY;
	endtask

	task automatic sample_point();
		@(negedge clk_sys);
	endtask

	task automatic drive_bus(input logic [15:0] a, input logic [7:0] d, input logic mreq,
			input logic iorq, input logic rd, input logic wr);
		bus = '{addr: a, dout: d, mreq: mreq, iorq: iorq, rd: rd, wr: wr, m1: 1'b0};
	endtask

	task automatic bus_idle();
		bus = '{addr: 16'hFFFF, dout: 8'hFF, default: 1'b0};
	endtask

	task automatic report_and_finish();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		sample_point();
		while (reset && n < RESET_TIMEOUT) begin
			sample_point();
			n++;
		end
		if (reset) begin
			$display("Reset was still high after %0d cycles", RESET_TIMEOUT);
			errors++;
			report_and_finish();
		end else begin
			next_cycle();
		end
	endtask

	task automatic apply_reset(input machine_e m);
		bus_idle();
		machine = m;
		-> reset_req;
		wait_reset_release();
	endtask

	// ==================================================
	// Compare tasks
	// ==================================================

	task automatic check_mem(input string name, input mem_req_t exp);
		checks++;
		if (mem !== exp) begin
			errors++;
			$display("[ERROR] %s: expected addr %h din %h rd/we %b%b, actual addr %h din %h rd/we %b%b",
				name, exp.addr, exp.din, exp.rd, exp.we, mem.addr, mem.din, mem.rd, mem.we);
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_ula(input string name, input ula_t exp);
		ula_t act;
		act = '{border: border, ear: ear, mic: mic};
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: expected border %h ear %b mic %b, actual border %h ear %b mic %b",
				name, exp.border, exp.ear, exp.mic, act.border, act.ear, act.mic);
		end
	endtask

	// ==================================================
	// Bus cycles
	// ==================================================

	// One memory cycle with the mapping checked mid-cycle
	task automatic check_access(input string name, input logic [15:0] a, input logic wr,
			input mem_addr_t exp_addr, input logic exp_we);
		logic [7:0] d;
		mem_req_t   exp;
		d = rand_byte();
		drive_bus(a, d, 1'b1, 1'b0, ~wr, wr);
		sample_point();
		exp = '{addr: exp_addr, din: d, rd: ~wr, we: exp_we};
		check_mem(name, exp);
		next_cycle();
		bus_idle();
	endtask

	task automatic io_write(input logic [15:0] a, input logic [7:0] d);
		drive_bus(a, d, 1'b0, 1'b1, 1'b0, 1'b1);
		next_cycle();
		bus_idle();
		next_cycle();
	endtask

	// Keyboard and Kempston data are registered so the read is sampled one cycle in
	task automatic read_port(input string name, input logic [15:0] a, input logic [7:0] exp);
		drive_bus(a, 8'h00, 1'b0, 1'b1, 1'b1, 1'b0);
		next_cycle();
		sample_point();
		check_byte(name, exp, cpu_din);
		next_cycle();
		bus_idle();
	endtask

	// ==================================================
	// Directed tests
	// ==================================================

	task automatic test_zx128_reset();
		mem_req_t exp;
		check_access("zx128 slot0", 16'h0123, 1'b0, rom_addr(4'b0110, 16'h0123), 1'b0);
		check_access("zx128 slot1", 16'h4567, 1'b0, ram_addr(3'd5, 16'h4567), 1'b0);
		check_access("zx128 slot2", 16'h89AB, 1'b0, ram_addr(3'd2, 16'h89AB), 1'b0);
		check_access("zx128 slot3", 16'hCDEF, 1'b0, ram_addr(3'd0, 16'hCDEF), 1'b0);
		// Read strobe without mreq
		drive_bus(16'hCDEF, 8'h5A, 1'b0, 1'b0, 1'b1, 1'b0);
		sample_point();
		exp = '{addr: ram_addr(3'd0, 16'hCDEF), din: 8'h5A, rd: 1'b0, we: 1'b0};
		check_mem("zx128 no mreq", exp);
		next_cycle();
		bus_idle();
	endtask

	task automatic test_7ffd_paging();
		logic [7:0] r;
		logic [7:0] k;
		r = rand_byte();
		io_write(16'h7FFD, {3'b000, r[4], 1'b0, r[2:0]});
		check_access("7ffd slot3", 16'hC042, 1'b0, ram_addr(r[2:0], 16'hC042), 1'b0);
		check_access("7ffd rom", 16'h1042, 1'b0, rom_addr({3'b011, r[4]}, 16'h1042), 1'b0);
		// Lock goes in with the last accepted page
		k = rand_byte();
		io_write(16'h7FFD, {2'b00, 1'b1, k[4], 1'b0, k[2:0]});
		check_access("7ffd lock slot3", 16'hE000, 1'b1, ram_addr(k[2:0], 16'hE000), 1'b1);
		io_write(16'h7FFD, {3'b000, ~k[4], 1'b0, ~k[2:0]});
		check_access("7ffd locked slot3", 16'hC100, 1'b0, ram_addr(k[2:0], 16'hC100), 1'b0);
		check_access("7ffd locked rom", 16'h0100, 1'b0, rom_addr({3'b011, k[4]}, 16'h0100), 1'b0);
	endtask

	task automatic test_zx48();
		apply_reset(MACH_ZX48);
		check_access("zx48 rom", 16'h2345, 1'b0, rom_addr(4'b1111, 16'h2345), 1'b0);
		io_write(16'h7FFD, 8'h17);
		check_access("zx48 slot3", 16'hC100, 1'b0, ram_addr(3'd0, 16'hC100), 1'b0);
		check_access("zx48 rom after 7ffd", 16'h0200, 1'b0, rom_addr(4'b1111, 16'h0200), 1'b0);
		check_access("zx48 rom write", 16'h0100, 1'b1, rom_addr(4'b1111, 16'h0100), 1'b0);
		check_access("zx48 slot2 write", 16'h8100, 1'b1, ram_addr(3'd2, 16'h8100), 1'b1);
	endtask

	task automatic test_plus3();
		int          i;
		int          s;
		logic [15:0] a;
		logic [2:0]  b;
		apply_reset(MACH_PLUS3);
		for (i = 0; i < 4; i++) begin
			io_write(16'h1FFD, {5'b00000, i[1], 2'b00});
			io_write(16'h7FFD, {3'b000, i[0], 4'b0000});
			check_access($sformatf("plus3 rom %0d", i), 16'h0ABC, 1'b0,
				rom_addr({2'b10, i[1], i[0]}, 16'h0ABC), 1'b0);
		end
		for (i = 0; i < 4; i++) begin
			io_write(16'h1FFD, {5'b00000, i[1:0], 1'b1});
			for (s = 0; s < 4; s++) begin
				a = {s[1:0], 14'h0321};
				b = special_bank(i, s);
				check_access($sformatf("plus3 cfg%0d slot%0d", i, s), a, 1'b0,
					ram_addr(b, a), 1'b0);
			end
			// All-RAM mode makes slot 0 writable
			b = special_bank(i, 0);
			check_access($sformatf("plus3 cfg%0d write", i), 16'h0321, 1'b1,
				ram_addr(b, 16'h0321), 1'b1);
		end
	endtask

	task automatic test_ula();
		logic [7:0] d;
		logic [7:0] h;
		ula_t       exp;
		joy_mode = JOY_NONE;
		d = rand_byte();
		io_write(16'h00FE, d);
		sample_point();
		exp = '{border: d[2:0], ear: d[4], mic: d[3]};
		check_ula("ula write", exp);
		next_cycle();
		// Level held over two edges writes once
		h = rand_byte();
		drive_bus(16'hFEFE, h, 1'b0, 1'b1, 1'b0, 1'b1);
		next_cycle();
		drive_bus(16'hFEFE, ~h, 1'b0, 1'b1, 1'b0, 1'b1);
		next_cycle();
		bus_idle();
		sample_point();
		exp = '{border: h[2:0], ear: h[4], mic: h[3]};
		check_ula("ula held write", exp);
		next_cycle();
		d = rand_byte();
		key_data = d[4:0];
		tape_in = d[7];
		read_port("port fe read", 16'hFEFE, {1'b1, d[7], 1'b1, d[4:0]});
		ram_dout = rand_byte();
		drive_bus(16'h5B00, 8'h00, 1'b1, 1'b0, 1'b1, 1'b0);
		sample_point();
		check_byte("memory read data", ram_dout, cpu_din);
		next_cycle();
		bus_idle();
	endtask

	task automatic test_joysticks();
		joy_t       j0;
		joy_t       j1;
		logic [7:0] d;
		logic [4:0] row;
		d = rand_byte();
		j0 = d[5:0];
		d = rand_byte();
		j1 = d[5:0];
		joy0 = j0;
		joy1 = j1;
		key_data = 5'h1F;
		tape_in = 1'b0;
		joy_mode = JOY_KEMPSTON;
		read_port("kempston", 16'h001F, {2'b00, j0 | j1});
		joy_mode = JOY_NONE;
		read_port("kempston off", 16'h001F, 8'h00);
		joy_mode = JOY_SINCLAIR1;
		row = 5'h1F & ~{j0.left, j0.right, j0.down, j0.up, j0.fire1};
		read_port("sinclair1 row", 16'hEFFE, {3'b101, row});
		read_port("sinclair1 other row", 16'hF7FE, 8'hBF);
		joy_mode = JOY_SINCLAIR2;
		row = 5'h1F & ~{j1.fire1, j1.up, j1.down, j1.right, j1.left};
		read_port("sinclair2 row", 16'hF7FE, {3'b101, row});
		read_port("sinclair2 other row", 16'hEFFE, 8'hBF);
		read_port("unselected port", 16'h00FF, 8'hFF);
		sample_point();
		check_byte("idle bus", 8'hFF, cpu_din);
		next_cycle();
	endtask

	// ==================================================
	// Main sequence
	// ==================================================

	initial begin
		errors = 0;
		checks = 0;
		lfsr = 8'd85;
		machine = MACH_ZX128;
		bus_idle();
		ram_dout = 8'h00;
		key_data = 5'h1F;
		tape_in = 1'b0;
		joy0 = '0;
		joy1 = '0;
		joy_mode = JOY_NONE;
		wait_reset_release();
		test_zx128_reset();
		test_7ffd_paging();
		test_zx48();
		test_plus3();
		test_ula();
		test_joysticks();
		report_and_finish();
	end

endmodule

// ==== zx_mem_checker.sv ====
/*
 * Concurrent assertions on the paging core top level
 * Strobe exclusion, ROM write protect, ULA reset values
 */

`timescale 1ns/100ps

module zx_mem_checker
	import spectrum_mem_pkg::*;
(
	input logic       clk_sys,
	input logic       reset,
	input mem_req_t   mem,
	input logic [2:0] border,
	input logic       ear,
	input logic       mic
);

	a_rd_we_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(mem.rd && mem.we))
		else $error("Memory read and write strobes high together");

	// ROM tag sits just above the page field
	a_rom_no_write: assert property (@(posedge clk_sys) disable iff (reset)
		(mem.addr[20:18] == ROM_BASE_TAG) |-> !mem.we)
		else $error("Write strobe high on a ROM address");

	a_ula_reset: assert property (@(posedge clk_sys)
		reset |=> (border == 3'd0) && !ear && !mic)
		else $error("ULA outputs not cleared after reset");

endmodule

bind zx_mem_top zx_mem_checker u_checker (
	.clk_sys (clk_sys),
	.reset   (reset),
	.mem     (mem),
	.border  (border),
	.ear     (ear),
	.mic     (mic)
);

// ==== zx_mem_top.sv ====
/*
 * Spectrum paging and I/O core, top level
 */

`timescale 1ns/100ps

module zx_mem_top
	import spectrum_bus_pkg::*, spectrum_mem_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  machine_e   machine,
	input  cpu_bus_t   bus,
	input  logic [7:0] ram_dout,
	input  logic [4:0] key_data,
	input  logic       tape_in,
	input  joy_t       joy0,
	input  joy_t       joy1,
	input  joy_mode_e  joy_mode,
	output mem_req_t   mem,
	output logic [7:0] cpu_din,
	output logic [2:0] border,
	output logic       ear,
	output logic       mic
);

	page_state_t page_state;
	logic [4:0]  kbd_row;
	logic [7:0]  kempston_byte;

	page_registers u_page_registers (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.machine    (machine),
		.bus        (bus),
		.page_state (page_state)
	);

	address_mapper u_address_mapper (
		.bus        (bus),
		.page_state (page_state),
		.mem        (mem)
	);

	joystick_mapper u_joystick_mapper (
		.clk_sys       (clk_sys),
		.bus           (bus),
		.key_data      (key_data),
		.joy0          (joy0),
		.joy1          (joy1),
		.joy_mode      (joy_mode),
		.kbd_row       (kbd_row),
		.kempston_byte (kempston_byte)
	);

	io_ports u_io_ports (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.bus           (bus),
		.ram_dout      (ram_dout),
		.kbd_row       (kbd_row),
		.kempston_byte (kempston_byte),
		.tape_in       (tape_in),
		.cpu_din       (cpu_din),
		.border        (border),
		.ear           (ear),
		.mic           (mic)
	);

endmodule

// ==== io_ports.sv ====
/*
 * ULA port and CPU read data
 * Border/EAR/MIC latch, read mux for memory, Kempston and port FE
 */

`timescale 1ns/100ps

module io_ports
	import spectrum_bus_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  cpu_bus_t   bus,
	input  logic [7:0] ram_dout,
	input  logic [4:0] kbd_row,
	input  logic [7:0] kempston_byte,
	input  logic       tape_in,
	output logic [7:0] cpu_din,
	output logic [2:0] border,
	output logic       ear,
	output logic       mic
);

	logic io_wr;
	logic io_wr_d;
	logic io_rd;
	logic kempston_sel;

	assign io_wr = bus.iorq & bus.wr & ~bus.m1;
	assign io_rd = bus.iorq & bus.rd & ~bus.m1;

	assign kempston_sel = (bus.addr[5:0] == PORT_KEMPSTON_LO);

	// ==================================================
	// ULA port, any even address
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_d <= 1'b0;
			border  <= 3'd0;
			ear     <= 1'b0;
			mic     <= 1'b0;
		end else begin
			io_wr_d <= io_wr;
			if (io_wr && !io_wr_d && !bus.addr[0]) begin
				border <= bus.dout[2:0];
				ear    <= bus.dout[4];
				mic    <= bus.dout[3];
			end
		end
	end

	// ==================================================
	// CPU read data
	// ==================================================

	always_comb begin
		if (bus.mreq) begin
			cpu_din = ram_dout;
		end else if (io_rd && kempston_sel) begin
			cpu_din = kempston_byte;
		end else if (io_rd && !bus.addr[0]) begin
			cpu_din = {1'b1, tape_in, 1'b1, kbd_row};
		end else begin
			// Floating bus reads as all ones
			cpu_din = 8'hFF;
		end
	end

endmodule

// ==== joystick_mapper.sv ====
/*
 * Joystick mapping
 * Kempston port byte and Sinclair 1/2 masking of keyboard rows
 */

`timescale 1ns/100ps

module joystick_mapper
	import spectrum_bus_pkg::*;
(
	input  logic       clk_sys,
	input  cpu_bus_t   bus,
	input  logic [4:0] key_data,
	input  joy_t       joy0,
	input  joy_t       joy1,
	input  joy_mode_e  joy_mode,
	output logic [4:0] kbd_row,
	output logic [7:0] kempston_byte
);

	logic [5:0] joy_any;
	logic [4:0] sinclair1;
	logic [4:0] sinclair2;
	logic [4:0] joy_mask;

	assign joy_any = joy0 | joy1;

	// Sinclair 1 on keys 6..0, row selected by A12 low
	assign sinclair1 = (joy_mode == JOY_SINCLAIR1) ?
		{joy0.left, joy0.right, joy0.down, joy0.up, joy0.fire1} : 5'b00000;

	// Sinclair 2 on keys 1..5, row selected by A11 low
	assign sinclair2 = (joy_mode == JOY_SINCLAIR2) ?
		{joy1.fire1, joy1.up, joy1.down, joy1.right, joy1.left} : 5'b00000;

	// Key lines are active low, a pressed direction pulls the bit down
	assign joy_mask = ({5{bus.addr[12]}} | ~sinclair1) & ({5{bus.addr[11]}} | ~sinclair2);

	always_ff @(posedge clk_sys) begin
		kbd_row       <= key_data & joy_mask;
		kempston_byte <= (joy_mode == JOY_KEMPSTON) ? {2'b00, joy_any} : 8'h00;
	end

endmodule

// ==== address_mapper.sv ====
/*
 * CPU address to external memory mapping
 * ROM page select, RAM bank select, +3 all-RAM modes, ROM write protect
 */

`timescale 1ns/100ps

module address_mapper
	import spectrum_bus_pkg::*, spectrum_mem_pkg::*;
(
	input  cpu_bus_t    bus,
	input  page_state_t page_state,
	output mem_req_t    mem
);

	logic       is_plus3;
	logic       is_zx48;
	logic       special;
	logic [1:0] slot;
	logic [3:0] rom_page;
	logic [2:0] bank;
	logic       rom_sel;

	assign is_plus3 = (page_state.machine == MACH_PLUS3);
	assign is_zx48  = (page_state.machine == MACH_ZX48);
	assign special  = page_state.p1ffd.spec.special;
	assign slot     = bus.addr[15:14];

	// 128 editor/BASIC pair at 6/7, 48K BASIC at 15, +3 at 8..11
	assign rom_page = is_plus3 ?
		{1'b1, 1'b0, page_state.p1ffd.norm.rom_hi, page_state.p7ffd.rom_lo} :
		{is_zx48, 1'b1, 1'b1, is_zx48 | page_state.p7ffd.rom_lo};

	always_comb begin
		rom_sel = 1'b0;
		bank    = page_state.p7ffd.bank;
		if (special) begin
			// All-RAM tables {0,1,2,3} {4,5,6,7} {4,5,6,3} {4,7,6,3}
			case (page_state.p1ffd.spec.cfg)
				2'd0: bank = {1'b0, slot};
				2'd1: bank = {1'b1, slot};
				2'd2: bank = (slot == 2'd3) ? 3'd3 : {1'b1, slot};
				default: begin
					case (slot)
						2'd0: bank = 3'd4;
						2'd1: bank = 3'd7;
						2'd2: bank = 3'd6;
						default: bank = 3'd3;
					endcase
				end
			endcase
		end else begin
			case (slot)
				2'd0: rom_sel = 1'b1;
				2'd1: bank = BANK_SLOT1;
				2'd2: bank = BANK_SLOT2;
				default: bank = page_state.p7ffd.bank;
			endcase
		end
	end

	// ==================================================
	// Memory request
	// ==================================================

	assign mem.addr = rom_sel ?
		{4'b0000, ROM_BASE_TAG, rom_page, bus.addr[13:0]} :
		{4'b0000, RAM_BASE_TAG, bank, bus.addr[13:0]};

	assign mem.din = bus.dout;
	assign mem.rd  = bus.mreq & bus.rd;

	// Slot 0 is ROM unless all-RAM mode is on
	assign mem.we = bus.mreq & bus.wr & (special | (slot != 2'd0));

endmodule

// ==== page_registers.sv ====
/*
 * 128K and +3 paging registers
 * Machine type latch, 7FFD and 1FFD with paging lock
 */

`timescale 1ns/100ps

module page_registers
	import spectrum_bus_pkg::*, spectrum_mem_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  machine_e    machine,
	input  cpu_bus_t    bus,
	output page_state_t page_state
);

	machine_e    machine_q;
	page_7ffd_t  p7ffd_q;
	plus3_page_u p1ffd_q;

	logic io_wr;
	logic io_wr_d;
	logic io_wr_edge;
	logic is_plus3;
	logic locked;
	logic sel_7ffd;
	logic sel_1ffd;

	// Write level, acted on at its rising edge only
	assign io_wr      = bus.iorq & bus.wr & ~bus.m1;
	assign io_wr_edge = io_wr & ~io_wr_d;

	assign is_plus3 = (machine_q == MACH_PLUS3);

	// 48K has no paging at all
	assign locked = (machine_q == MACH_ZX48) | p7ffd_q.lock;

	// +3 decodes A14 too, so 1FFD does not alias onto 7FFD
	assign sel_7ffd = ~bus.addr[15] & ~bus.addr[1] & (bus.addr[14] | ~is_plus3);

	assign sel_1ffd = (bus.addr[15:13] == 3'b000) & bus.addr[12] & ~bus.addr[1] & is_plus3;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_d   <= 1'b0;
			machine_q <= machine;
			p7ffd_q   <= '0;
			p1ffd_q   <= '0;
		end else begin
			io_wr_d <= io_wr;
			if (io_wr_edge && !locked) begin
				if (sel_7ffd) begin
					p7ffd_q <= bus.dout;
				end else if (sel_1ffd) begin
					p1ffd_q <= bus.dout;
				end
			end
		end
	end

	assign page_state = '{machine: machine_q, p7ffd: p7ffd_q, p1ffd: p1ffd_q};

endmodule

// ==== spectrum_mem_pkg.sv ====
/*
 * Memory map and paging definitions
 * Machine enum, address tags, 7FFD/1FFD register layouts,
 * paging state and external memory request
 */

package spectrum_mem_pkg;

	typedef enum logic [1:0] {
		MACH_ZX48  = 2'd0,
		MACH_ZX128 = 2'd1,
		MACH_PLUS3 = 2'd2
	} machine_e;

	typedef logic [24:0] mem_addr_t;

	// ==================================================
	// Memory map
	// ==================================================

	// ROM pages sit above the RAM banks in external memory
	localparam logic [2:0] ROM_BASE_TAG = 3'b101;
	localparam logic [3:0] RAM_BASE_TAG = 4'b0000;

	// Fixed banks at 4000 and 8000
	localparam logic [2:0] BANK_SLOT1 = 3'd5;
	localparam logic [2:0] BANK_SLOT2 = 3'd2;

	// ==================================================
	// Paging registers
	// ==================================================

	typedef struct packed {
		logic [1:0] spare;
		logic       lock;
		logic       rom_lo;
		logic       screen;
		logic [2:0] bank;
	} page_7ffd_t;

	// 1FFD in normal paging mode
	typedef struct packed {
		logic [3:0] spare;
		logic       motor;
		logic       rom_hi;
		logic       unused;
		logic       special;
	} plus3_norm_t;

	// 1FFD in all-RAM mode, cfg picks one of four bank tables
	typedef struct packed {
		logic [4:0] spare;
		logic [1:0] cfg;
		logic       special;
	} plus3_spec_t;

	typedef union packed {
		plus3_norm_t norm;
		plus3_spec_t spec;
	} plus3_page_u;

	typedef struct packed {
		machine_e    machine;
		page_7ffd_t  p7ffd;
		plus3_page_u p1ffd;
	} page_state_t;

	typedef struct packed {
		mem_addr_t  addr;
		logic [7:0] din;
		logic       rd;
		logic       we;
	} mem_req_t;

endpackage

// ==== spectrum_bus_pkg.sv ====
/*
 * CPU bus definitions for the Spectrum paging core
 * Bus struct, joystick types, I/O port decode constants
 */

package spectrum_bus_pkg;

	// CPU bus as seen by the core, all strobes active high
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dout;
		logic        mreq;
		logic        iorq;
		logic        rd;
		logic        wr;
		logic        m1;
	} cpu_bus_t;

	// Bit order matches the Kempston port layout
	typedef struct packed {
		logic fire2;
		logic fire1;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_t;

	typedef enum logic [1:0] {
		JOY_KEMPSTON  = 2'd0,
		JOY_SINCLAIR1 = 2'd1,
		JOY_SINCLAIR2 = 2'd2,
		JOY_NONE      = 2'd3
	} joy_mode_e;

	// ==================================================
	// Port decode
	// ==================================================

	// Kempston answers on any port with A5..A0 = 1F
	localparam logic [5:0] PORT_KEMPSTON_LO = 6'h1F;

endpackage
